// ==== mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath widths fixed by the instruction set
`define DATA_W 32
`define REG_W 5
`define JUMP_W 11
`define FUNCT_W 6

//////////////////////////////
// R-type funct codes
//////////////////////////////
`define FUNCT_ADD 6'h20
`define FUNCT_SUB 6'h22
`define FUNCT_AND 6'h24
`define FUNCT_OR 6'h25
`define FUNCT_NOR 6'h27
`define FUNCT_SLT 6'h2A

`endif

// ==== isa_pkg.sv ====
`include "mips_params.svh"

package isa_pkg;

    // First level ALU selector, set by decode
    typedef enum logic [1:0] {
        MEM_ADD = 2'b00,
        BR_SUB  = 2'b01,
        R_FUNCT = 2'b10,
        IMM_OR  = 2'b11
    } alu_op_t;

    // Operand source chosen by forwarding
    typedef enum logic [1:0] {
        FWD_REG    = 2'b00,
        FWD_MEM_WB = 2'b01,
        FWD_EX_MEM = 2'b10
    } fwd_sel_t;

    //////////////////////////////
    // Immediate word, two views
    //////////////////////////////
    // Whole word is the sign-extended immediate
    // Low bits double as shamt and funct for R-type
    typedef union packed {
        logic [`DATA_W-1:0] word;
        struct packed {
            logic [`DATA_W-`REG_W-`FUNCT_W-1:0] upper;
            logic [`REG_W-1:0]                  shamt;
            logic [`FUNCT_W-1:0]                funct;
        } r;
    } imm_word_u;

endpackage

// ==== pipe_pkg.sv ====
`include "mips_params.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Control bits carried down the pipe
    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
    } ctrl_t;

    //////////////////////////////
    // Pipeline bundles
    //////////////////////////////
    typedef struct packed {
        ctrl_t              ctrl;
        logic               alu_src;
        logic               reg_dst;
        alu_op_t            alu_op;
        logic [`DATA_W-1:0] rs_val;
        logic [`DATA_W-1:0] rt_val;
        logic [`REG_W-1:0]  rs_idx;
        logic [`REG_W-1:0]  rt_idx;
        imm_word_u          imm;
        logic [`REG_W-1:0]  rd_r_type;
        logic [`REG_W-1:0]  rd_i_type;
        logic [`JUMP_W-1:0] jump_dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [`DATA_W-1:0] result;
        logic [`DATA_W-1:0] store_val;
        logic [`REG_W-1:0]  reg_dest;
        logic [`JUMP_W-1:0] jump_dest;
        logic               zero;
    } ex_mem_t;

    // Writeback bundle from outside the stage
    typedef struct packed {
        logic               reg_write;
        logic [`REG_W-1:0]  reg_dest;
        logic [`DATA_W-1:0] value;
    } mem_wb_t;

endpackage

// ==== alu.sv ====
`include "mips_params.svh"

module alu
    import isa_pkg::*;
(
    input  alu_op_t              alu_op,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic [`DATA_W-1:0]   operand_a,
    input  logic [`DATA_W-1:0]   operand_b,
    output logic [`DATA_W-1:0]   result,
    output logic                 zero
);

    // Internal operation codes, second level
    localparam logic [2:0] CTL_ADD = 3'd0;
    localparam logic [2:0] CTL_SUB = 3'd1;
    localparam logic [2:0] CTL_AND = 3'd2;
    localparam logic [2:0] CTL_OR  = 3'd3;
    localparam logic [2:0] CTL_NOR = 3'd4;
    localparam logic [2:0] CTL_SLT = 3'd5;

    logic [2:0] alu_ctl;
    logic       signed_lt;

    //////////////////////////////
    // ALU control
    //////////////////////////////
    always_comb begin
        case (alu_op)
            MEM_ADD: alu_ctl = CTL_ADD;
            BR_SUB:  alu_ctl = CTL_SUB;
            IMM_OR:  alu_ctl = CTL_OR;
            R_FUNCT: begin
                case (funct)
                    `FUNCT_ADD: alu_ctl = CTL_ADD;
                    `FUNCT_SUB: alu_ctl = CTL_SUB;
                    `FUNCT_AND: alu_ctl = CTL_AND;
                    `FUNCT_OR:  alu_ctl = CTL_OR;
                    `FUNCT_NOR: alu_ctl = CTL_NOR;
                    `FUNCT_SLT: alu_ctl = CTL_SLT;
                    // Unknown funct falls back to add
                    default:    alu_ctl = CTL_ADD;
                endcase
            end
            default: alu_ctl = CTL_ADD;
        endcase
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////
    assign signed_lt = $signed(operand_a) < $signed(operand_b);

    always_comb begin
        case (alu_ctl)
            CTL_ADD: result = operand_a + operand_b;
            CTL_SUB: result = operand_a - operand_b;
            CTL_AND: result = operand_a & operand_b;
            CTL_OR:  result = operand_a | operand_b;
            CTL_NOR: result = ~(operand_a | operand_b);
            CTL_SLT: result = {{(`DATA_W-1){1'b0}}, signed_lt};
            default: result = operand_a + operand_b;
        endcase
    end

    // Branch compare uses this after a subtract
    assign zero = (result == '0);

endmodule

// ==== forward_unit.sv ====
`include "mips_params.svh"

module forward_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic [`REG_W-1:0] rs_idx,
    input  logic [`REG_W-1:0] rt_idx,
    input  logic [`REG_W-1:0] ex_mem_dest,
    input  logic              ex_mem_reg_write,
    input  mem_wb_t           mem_wb,
    output fwd_sel_t          fwd_a,
    output fwd_sel_t          fwd_b
);

    // Youngest writer wins; register 0 is never a real destination
    function automatic fwd_sel_t pick_src(
        input logic [`REG_W-1:0] src,
        input logic [`REG_W-1:0] ex_dest,
        input logic              ex_we,
        input mem_wb_t           wb
    );
        fwd_sel_t sel;
        if (ex_we && (ex_dest != '0) && (ex_dest == src)) begin
            sel = FWD_EX_MEM;
        end else if (wb.reg_write && (wb.reg_dest != '0)
                     && (wb.reg_dest == src)) begin
            sel = FWD_MEM_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    // Same rule for both source operands
    assign fwd_a = pick_src(rs_idx, ex_mem_dest, ex_mem_reg_write, mem_wb);
    assign fwd_b = pick_src(rt_idx, ex_mem_dest, ex_mem_reg_write, mem_wb);

endmodule

// ==== ex_mem_reg.sv ====
module ex_mem_reg
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    arst_n,
    input  ex_mem_t next,
    output ex_mem_t ex_mem
);

    // Whole bundle clears so no stale control bit leaks out of reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= next;
        end
    end

endmodule

// ==== execute.sv ====
`include "mips_params.svh"

module execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic               clock,
    input  logic               arst_n,
    input  id_ex_t             id_ex,
    input  fwd_sel_t           fwd_a,
    input  fwd_sel_t           fwd_b,
    input  logic [`DATA_W-1:0] wb_value,
    output ex_mem_t            ex_mem
);

    logic [`DATA_W-1:0] operand_a;
    logic [`DATA_W-1:0] fwd_b_val;
    logic [`DATA_W-1:0] operand_b;
    logic [`DATA_W-1:0] alu_result;
    logic               alu_zero;
    logic [`REG_W-1:0]  reg_dest;
    ex_mem_t            next;

    // Three-way forwarding mux
    function automatic logic [`DATA_W-1:0] fwd_mux(
        input fwd_sel_t           sel,
        input logic [`DATA_W-1:0] reg_val,
        input logic [`DATA_W-1:0] ex_val,
        input logic [`DATA_W-1:0] wb_val
    );
        logic [`DATA_W-1:0] val;
        case (sel)
            FWD_EX_MEM: val = ex_val;
            FWD_MEM_WB: val = wb_val;
            default:    val = reg_val;
        endcase
        return val;
    endfunction

    //////////////////////////////
    // Operand and destination select
    //////////////////////////////
    assign operand_a = fwd_mux(fwd_a, id_ex.rs_val, ex_mem.result, wb_value);
    assign fwd_b_val = fwd_mux(fwd_b, id_ex.rt_val, ex_mem.result, wb_value);
    assign operand_b = id_ex.alu_src ? id_ex.imm.word : fwd_b_val;
    assign reg_dest  = id_ex.reg_dst ? id_ex.rd_r_type : id_ex.rd_i_type;

    alu u_alu (
        .alu_op    (id_ex.alu_op),
        .funct     (id_ex.imm.r.funct),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (alu_result),
        .zero      (alu_zero)
    );

    //////////////////////////////
    // EX/MEM capture
    //////////////////////////////
    // Store data is forwarded B, not the immediate
    assign next.ctrl      = id_ex.ctrl;
    assign next.result    = alu_result;
    assign next.store_val = fwd_b_val;
    assign next.reg_dest  = reg_dest;
    assign next.jump_dest = id_ex.jump_dest;
    assign next.zero      = alu_zero;

    ex_mem_reg u_ex_mem_reg (
        .clock  (clock),
        .arst_n (arst_n),
        .next   (next),
        .ex_mem (ex_mem)
    );

endmodule

// ==== ex_subsystem.sv ====
module ex_subsystem
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    arst_n,
    input  id_ex_t  id_ex,
    input  mem_wb_t mem_wb,
    output ex_mem_t ex_mem
);

    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    // Compares against the instruction now in EX/MEM
    forward_unit u_forward_unit (
        .rs_idx           (id_ex.rs_idx),
        .rt_idx           (id_ex.rt_idx),
        .ex_mem_dest      (ex_mem.reg_dest),
        .ex_mem_reg_write (ex_mem.ctrl.reg_write),
        .mem_wb           (mem_wb),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b)
    );

    execute u_execute (
        .clock    (clock),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .wb_value (mem_wb.value),
        .ex_mem   (ex_mem)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clock
);

    // Free running, period of 8 units
    initial begin
        clock = 1'b0;
    end

    always begin
        #4 clock = ~clock;
    end

endmodule

// ==== tb_execute.sv ====
`include "mips_params.svh"

module tb_execute
    import isa_pkg::*;
    import pipe_pkg::*;
();

    logic    clock;
    logic    arst_n;
    id_ex_t  id_ex;
    mem_wb_t mem_wb;
    ex_mem_t ex_mem;

    // Vectors loaded from the stimulus file
    string   vec_name[$];
    id_ex_t  vec_id[$];
    mem_wb_t vec_wb[$];
    ex_mem_t vec_exp[$];

    int error_count = 0;
    int test_count  = 0;
    int fail_tests  = 0;
    int cycle_count = 0;
    int cycle_limit = 24;
    bit load_ok     = 1'b1;

    tb_clock_gen u_clock_gen (
        .clock (clock)
    );

    ex_subsystem uut (
        .clock  (clock),
        .arst_n (arst_n),
        .id_ex  (id_ex),
        .mem_wb (mem_wb),
        .ex_mem (ex_mem)
    );

    //////////////////////////////
    // Stimulus file
    //////////////////////////////
    task automatic load_vectors();
        string              line;
        string              name;
        int                 fd;
        int                 n;
        logic               rnd;
        logic               alu_src;
        logic               reg_dst;
        logic               wb_we;
        logic               e_zero;
        logic [1:0]         alu_op;
        logic [4:0]         ctrl;
        logic [4:0]         e_ctrl;
        logic [4:0]         drawn;
        logic [`REG_W-1:0]  rs_idx;
        logic [`REG_W-1:0]  rt_idx;
        logic [`REG_W-1:0]  rd_r;
        logic [`REG_W-1:0]  rd_i;
        logic [`REG_W-1:0]  wb_dest;
        logic [`REG_W-1:0]  e_dest;
        logic [`JUMP_W-1:0] jump;
        logic [`DATA_W-1:0] rs_val;
        logic [`DATA_W-1:0] rt_val;
        logic [`DATA_W-1:0] imm;
        logic [`DATA_W-1:0] wb_val;
        logic [`DATA_W-1:0] e_res;
        logic [`DATA_W-1:0] e_store;
        logic [31:0]        r;
        id_ex_t             id;
        mem_wb_t            wb;
        ex_mem_t            want;
        fd = $fopen("execute_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file execute_stim.txt");
            load_ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, rnd, ctrl, alu_src, reg_dst, alu_op, rs_val, rt_val, rs_idx,
                rt_idx, imm, rd_r, rd_i, jump, wb_we, wb_dest, wb_val,
                e_res, e_zero, e_dest, e_store, e_ctrl);
            if (n != 22) begin
                $display("Stimulus line could not be parsed: %s", line);
                load_ok = 1'b0;
                continue;
            end
            // Random lines draw the pass-through bits, reg_write stays from the file
            if (rnd) begin
                r      = $urandom;
                drawn  = (r[4:0] & 5'h17) | (ctrl & 5'h08);
                ctrl   = drawn;
                e_ctrl = drawn;
            end
            id.ctrl      = ctrl;
            id.alu_src   = alu_src;
            id.reg_dst   = reg_dst;
            id.alu_op    = alu_op_t'(alu_op);
            id.rs_val    = rs_val;
            id.rt_val    = rt_val;
            id.rs_idx    = rs_idx;
            id.rt_idx    = rt_idx;
            id.imm.word  = imm;
            id.rd_r_type = rd_r;
            id.rd_i_type = rd_i;
            id.jump_dest = jump;
            wb.reg_write = wb_we;
            wb.reg_dest  = wb_dest;
            wb.value     = wb_val;
            want.ctrl      = e_ctrl;
            want.result    = e_res;
            want.store_val = e_store;
            want.reg_dest  = e_dest;
            want.jump_dest = jump;
            want.zero      = e_zero;
            vec_name.push_back(name);
            vec_id.push_back(id);
            vec_wb.push_back(wb);
            vec_exp.push_back(want);
        end
        $fclose(fd);
        if (vec_name.size() == 0) begin
            $display("Stimulus file holds no vectors");
            load_ok = 1'b0;
        end
        cycle_limit = vec_name.size() + 4 + 20;
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic check_field(input string test, input string field,
                               input logic [31:0] want, input logic [31:0] got);
        assert (got === want) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test, field, want, got);
            error_count++;
        end
    endtask

    task automatic check_bundle(input string test, input ex_mem_t want);
        int errs_before;
        errs_before = error_count;
        check_field(test, "result", want.result, ex_mem.result);
        check_field(test, "zero", 32'(want.zero), 32'(ex_mem.zero));
        check_field(test, "reg_dest", 32'(want.reg_dest), 32'(ex_mem.reg_dest));
        check_field(test, "store_val", want.store_val, ex_mem.store_val);
        check_field(test, "jump_dest", 32'(want.jump_dest), 32'(ex_mem.jump_dest));
        check_field(test, "ctrl", 32'(want.ctrl), 32'(ex_mem.ctrl));
        test_count++;
        if (error_count == errs_before) begin
            $display("test %-12s done, ok", test);
        end else begin
            fail_tests++;
            $display("test %-12s done, %0d field errors", test, error_count - errs_before);
        end
    endtask

    //////////////////////////////
    // Sequencing
    //////////////////////////////
    task automatic run_reset();
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_bundle("reset", '0);
    endtask

    // Result of vector i-1 is visible after the edge that drives vector i
    task automatic run_vectors();
        for (int i = 0; i <= vec_name.size(); i++) begin
            @(posedge clock);
            if (i < vec_name.size()) begin
                id_ex  <= vec_id[i];
                mem_wb <= vec_wb[i];
            end else begin
                id_ex  <= '0;
                mem_wb <= '0;
            end
            @(negedge clock);
            if (i > 0) begin
                check_bundle(vec_name[i-1], vec_exp[i-1]);
            end
        end
    endtask

    initial begin
        arst_n <= 1'b0;
        id_ex  <= '0;
        mem_wb <= '0;
        void'($urandom(32'h67fa));
        load_vectors();
        if (!load_ok) begin
            $display("Run aborted, stimulus not usable");
            $display("Result: FAILED");
        end else begin
            run_reset();
            run_vectors();
            $display("Summary: %0d tests, %0d passed, %0d failed, %0d field errors",
                     test_count, test_count - fail_tests, fail_tests, error_count);
            if (error_count == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
        end
        $finish;
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// ==== execute_stim.txt ====
# name rnd ctrl alu_src reg_dst alu_op rs_val rt_val rs_idx rt_idx imm rd_r rd_i jump
#   wb_we wb_dest wb_val exp_result exp_zero exp_reg_dest exp_store_val exp_ctrl, all hex
lw_add 0 1c 1 0 0 100 55 1 2 10 0 5 0 0 0 0 110 0 5 55 1c
sw_add_neg 0 02 1 0 0 200 deadbeef 6 7 fffffff8 0 7 12 0 0 0 1f8 0 7 deadbeef 02
beq_equal 0 01 0 0 1 1234 1234 8 9 4 0 9 0 0 0 0 0 1 9 1234 01
bne_unequal 0 01 0 0 1 1234 1233 8 9 4 0 9 0 0 0 0 1 0 9 1233 01
ori_imm 0 08 1 0 3 f0f0 0 a b f0f 0 b 0 0 0 0 ffff 0 b 0 08
r_add_ovf 0 08 0 1 2 7fffffff 1 c d 20 e d 0 0 0 0 80000000 0 e 1 08
r_sub_neg 0 08 0 1 2 5 7 f 10 22 11 10 0 0 0 0 fffffffe 0 11 7 08
r_and 0 08 0 1 2 ff00ff00 0ff00ff0 1 2 24 3 2 0 0 0 0 0f000f00 0 3 0ff00ff0 08
r_or 0 08 0 1 2 ff00ff00 0ff00ff0 4 5 25 6 5 0 0 0 0 fff0fff0 0 6 0ff00ff0 08
r_nor 0 08 0 1 2 ff00ff00 0ff00ff0 7 8 27 9 8 0 0 0 0 000f000f 0 9 0ff00ff0 08
slt_neg 0 08 0 1 2 fffffffb 3 a b 2a c b 0 0 0 0 1 0 c 3 08
slt_pos 0 08 0 1 2 3 fffffffb d e 2a f e 0 0 0 0 0 1 f fffffffb 08
bad_funct 0 08 0 1 2 10 20 10 11 3f 12 11 0 0 0 0 30 0 12 20 08
fwd_ex_a 0 08 0 1 2 dead 5 12 13 20 14 13 0 0 0 0 35 0 14 5 08
fwd_ex_b 0 08 0 1 2 100 bad 15 14 22 16 14 0 0 0 0 cb 0 16 35 08
fwd_wb_a 0 08 0 1 2 bad 2 19 1a 25 1b 1a 0 1 19 1000 1002 0 1b 2 08
fwd_ex_wins 0 08 0 1 2 bad 1 1b 1c 20 1d 1c 0 1 1b 7777 1003 0 1d 1 08
sw_fwd_wb 0 02 1 0 0 40 bad 1 3 8 0 3 0 1 3 cafe 48 0 3 cafe 02
r0_write 0 08 0 1 2 5 6 1 2 20 0 2 0 0 0 0 b 0 0 6 08
r0_no_fwd 0 08 0 1 2 0 0 0 0 25 4 0 0 1 0 999 0 1 4 0 08
wb_no_write 0 00 0 1 2 10 20 5 6 20 7 6 0 0 5 555 30 0 7 20 00
ex_no_write 0 08 0 1 2 1 2 7 8 20 9 8 0 0 0 0 3 0 9 2 08
rand_ctrl_a 1 00 1 0 0 100 77 a b 4 0 b 7ff 0 0 0 104 0 b 77 00
rand_ctrl_b 1 08 0 1 2 ffff 0f0f c d 24 e d 2aa 0 0 0 0f0f 0 e 0f0f 08
sw_fwd_ex 0 02 1 0 0 80 bad 1 e 4 0 e 0 0 0 0 84 0 e f0f 02
jump_pass 0 00 1 0 0 0 0 1 2 0 0 2 555 0 0 0 0 1 2 0 00

// ==== filelist.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
alu.sv
forward_unit.sv
ex_mem_reg.sv
execute.sv
ex_subsystem.sv
tb_clock_gen.sv
tb_execute.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module tb_execute

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_execute
	./obj_dir/Vtb_execute | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
